// File: cal_pkg.sv
`default_nettype none

package cal_pkg;

	////////////////////////////////////////
	// Counter sizing
	////////////////////////////////////////

	localparam int CNT_W = 12;	// Pulse counter width

	////////////////////////////////////////
	// Mode and select encodings
	////////////////////////////////////////

	// TTC source mode as set by slow control
	// Only skew-clear mode routes the calibration pulses
	typedef enum logic [1:0] {
		mode_ff_emu   = 2'b00,	// Retired fast-feedback emulation
		mode_ff_eem   = 2'b01,	// Retired
		mode_skew_clr = 2'b10
	} ttc_mode_e;

	typedef enum logic {
		sel_ext = 1'b0,	// External capacitor counter
		sel_inj = 1'b1	// Injection counter
	} cnt_sel_e;

	////////////////////////////////////////
	// Channel pairs
	////////////////////////////////////////

	typedef struct packed {
		logic ext;	// External capacitor pulse
		logic inj;	// Injection pulse
	} pulse_pair_t;

	typedef struct packed {
		logic [CNT_W-1:0] ext;
		logic [CNT_W-1:0] inj;
	} count_pair_t;

endpackage

`default_nettype wire

// File: cal_pulse_route.sv
`timescale 1ns/10ps
`default_nettype none

module cal_pulse_route (
	input  cal_pkg::pulse_pair_t skw_pulse,	// Skew-matched pulses
	input  cal_pkg::pulse_pair_t lv_pulse,	// Level-translated copies
	input  cal_pkg::ttc_mode_e   ttc_src,
	output cal_pkg::pulse_pair_t cal_pulse,
	output logic                 trg_pulse
);

	////////////////////////////////////////
	// Pulse routing
	////////////////////////////////////////

	// No clock anywhere in here
	// Outgoing pulses keep the timing of the incoming ones

	always_comb begin
		case (ttc_src)
			cal_pkg::mode_skew_clr: begin
				cal_pulse = skw_pulse;
			end
			default: begin
				// Retired modes hold both lines low
				cal_pulse = '0;
			end
		endcase
	end

	////////////////////////////////////////
	// Trigger
	////////////////////////////////////////

	// Either level copy fires the trigger in every mode
	assign trg_pulse = lv_pulse.ext | lv_pulse.inj;

endmodule

`default_nettype wire

// File: cal_pulse_counter.sv
`timescale 1ns/10ps
`default_nettype none

module cal_pulse_counter #(
	parameter int TMR = 0	// 1 selects triplicated voted logic
) (
	input  logic                 CLK40,
	input  logic                 RST_RESYNC,
	input  cal_pkg::pulse_pair_t cal_pulse,
	output cal_pkg::count_pair_t counts
);

	localparam int N_CH   = 2;
	localparam int CH_EXT = 1;
	localparam int CH_INJ = 0;

	logic [N_CH-1:0]                     pls;	// Routed pulse per channel
	logic [N_CH-1:0][cal_pkg::CNT_W-1:0] cnt;	// Counter value per channel

	assign pls[CH_EXT] = cal_pulse.ext;
	assign pls[CH_INJ] = cal_pulse.inj;

	assign counts = '{ext: cnt[CH_EXT], inj: cnt[CH_INJ]};

	////////////////////////////////////////
	// Majority voters
	////////////////////////////////////////

	function automatic logic vote_bit(
		input logic a,
		input logic b,
		input logic c
	);
		return (a & b) | (b & c) | (a & c);
	endfunction

	// Bitwise two-of-three
	function automatic logic [cal_pkg::CNT_W-1:0] vote_cnt(
		input logic [cal_pkg::CNT_W-1:0] a,
		input logic [cal_pkg::CNT_W-1:0] b,
		input logic [cal_pkg::CNT_W-1:0] c
	);
		return (a & b) | (b & c) | (a & c);
	endfunction

	generate
		if (TMR == 1) begin : g_tmr

			////////////////////////////////////////
			// Triplicated edge detect and counters
			////////////////////////////////////////

			for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
				(* syn_preserve = "true" *) logic                      pls_r [3];
				(* syn_preserve = "true" *) logic [cal_pkg::CNT_W-1:0] cnt_r [3];

				logic                      vt_pls [3];	// Voted delayed pulse per copy
				logic [cal_pkg::CNT_W-1:0] vt_cnt [3];	// Voted count per copy
				logic                      inc    [3];

				// Each copy has its own voter so one upset cannot spread
				always_comb begin
					for (int i = 0; i < 3; i++) begin
						vt_pls[i] = vote_bit(pls_r[0], pls_r[1], pls_r[2]);
						vt_cnt[i] = vote_cnt(cnt_r[0], cnt_r[1], cnt_r[2]);
						inc[i]    = pls[ch] & ~vt_pls[i];	// Live pulse against delayed copy
					end
				end

				always_ff @(posedge CLK40) begin
					for (int i = 0; i < 3; i++) begin
						pls_r[i] <= pls[ch];
					end
				end

				// Every copy reloads from the voted value
				always_ff @(posedge CLK40 or posedge RST_RESYNC) begin
					if (RST_RESYNC) begin
						for (int i = 0; i < 3; i++) begin
							cnt_r[i] <= '0;
						end
					end else begin
						for (int i = 0; i < 3; i++) begin
							cnt_r[i] <= inc[i] ? vt_cnt[i] + 1'b1 : vt_cnt[i];
						end
					end
				end

				assign cnt[ch] = vt_cnt[0];
			end

		end else begin : g_plain

			////////////////////////////////////////
			// Single edge detect and counters
			////////////////////////////////////////

			for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
				logic                      pls_r1;
				logic                      pls_r2;
				logic [cal_pkg::CNT_W-1:0] cnt_r;
				logic                      inc;

				assign inc = pls_r1 & ~pls_r2;	// Rising edge one cycle late

				always_ff @(posedge CLK40) begin
					pls_r1 <= pls[ch];
					pls_r2 <= pls_r1;
				end

				always_ff @(posedge CLK40 or posedge RST_RESYNC) begin
					if (RST_RESYNC) begin
						cnt_r <= '0;
					end else if (inc) begin
						cnt_r <= cnt_r + 1'b1;	// Wraps to zero after 4095
					end
				end

				assign cnt[ch] = cnt_r;
			end

		end
	endgenerate

endmodule

`default_nettype wire

// File: cal_count_readout.sv
`timescale 1ns/10ps
`default_nettype none

module cal_count_readout (
	input  logic                      CLK40,
	input  logic                      RST_RESYNC,
	input  cal_pkg::count_pair_t      counts,
	input  logic                      rd_strobe,	// One-cycle read request
	input  cal_pkg::cnt_sel_e         rd_sel,
	output logic [cal_pkg::CNT_W-1:0] rd_data,
	output logic                      rd_valid
);

	cal_pkg::count_pair_t snap;	// Both counters from one cycle
	cal_pkg::cnt_sel_e    sel_q;	// Channel picked by the last strobe

	////////////////////////////////////////
	// Snapshot capture
	////////////////////////////////////////

	// Every strobe takes a fresh snapshot
	// Back-to-back strobes are each served
	always_ff @(posedge CLK40 or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			snap     <= '0;
			sel_q    <= cal_pkg::sel_ext;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_strobe;
			if (rd_strobe) begin
				snap  <= counts;
				sel_q <= rd_sel;
			end
		end
	end

	////////////////////////////////////////
	// Channel select
	////////////////////////////////////////

	// Holds the snapshot value until the next strobe
	always_comb begin
		case (sel_q)
			cal_pkg::sel_inj: begin
				rd_data = snap.inj;
			end
			default: begin
				rd_data = snap.ext;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: cal_subsys_top.sv
`timescale 1ns/10ps
`default_nettype none

module cal_subsys_top #(
	parameter int TMR = 1	// Triplicated counters by default
) (
	input  logic                      CLK40,
	input  logic                      RST_RESYNC,
	input  cal_pkg::pulse_pair_t      skw_pulse,
	input  cal_pkg::pulse_pair_t      lv_pulse,
	input  cal_pkg::ttc_mode_e        ttc_src,
	input  logic                      rd_strobe,
	input  cal_pkg::cnt_sel_e         rd_sel,
	output cal_pkg::pulse_pair_t      cal_pulse,
	output logic                      trg_pulse,
	output logic [cal_pkg::CNT_W-1:0] rd_data,
	output logic                      rd_valid
);

	cal_pkg::count_pair_t counts;	// Live counter values

	////////////////////////////////////////
	// Stage 1 routing and trigger
	////////////////////////////////////////

	cal_pulse_route cal_pulse_route_inst (
		.skw_pulse (skw_pulse),
		.lv_pulse  (lv_pulse),
		.ttc_src   (ttc_src),
		.cal_pulse (cal_pulse),
		.trg_pulse (trg_pulse)
	);

	////////////////////////////////////////
	// Stage 2 pulse counters
	////////////////////////////////////////

	// Counts the routed pulses as they leave the board
	cal_pulse_counter #(
		.TMR (TMR)
	) cal_pulse_counter_inst (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.cal_pulse  (cal_pulse),
		.counts     (counts)
	);

	////////////////////////////////////////
	// Stage 3 slow-control readout
	////////////////////////////////////////

	cal_count_readout cal_count_readout_inst (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.counts     (counts),
		.rd_strobe  (rd_strobe),
		.rd_sel     (rd_sel),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

endmodule

`default_nettype wire

// File: cal_subsys_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cal_subsys_asserts (
	input logic                 CLK40,
	input logic                 RST_RESYNC,
	input cal_pkg::pulse_pair_t lv_pulse,
	input cal_pkg::ttc_mode_e   ttc_src,
	input logic                 rd_strobe,
	input cal_pkg::pulse_pair_t cal_pulse,
	input logic                 trg_pulse,
	input logic                 rd_valid
);

	////////////////////////////////////////
	// Readout
	////////////////////////////////////////

	// Two valid cycles need a strobe behind each
	a_valid_per_strobe: assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		(rd_valid && $past(rd_valid)) |-> ($past(rd_strobe, 1) && $past(rd_strobe, 2)))
		else $error("rd_valid held for two cycles without two strobes");

	////////////////////////////////////////
	// Routing and trigger
	////////////////////////////////////////

	a_trigger_or: assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		trg_pulse == (lv_pulse.ext | lv_pulse.inj))
		else $error("trg_pulse differs from OR of lv_pulse");

	a_retired_low: assert property (@(posedge CLK40) disable iff (RST_RESYNC)
		(ttc_src != cal_pkg::mode_skew_clr) |-> (cal_pulse == '0))
		else $error("cal_pulse active in a retired mode");	// Retired modes hold lines low

endmodule

bind cal_subsys_top cal_subsys_asserts cal_subsys_asserts_inst (
	.CLK40      (CLK40),
	.RST_RESYNC (RST_RESYNC),
	.lv_pulse   (lv_pulse),
	.ttc_src    (ttc_src),
	.rd_strobe  (rd_strobe),
	.cal_pulse  (cal_pulse),
	.trg_pulse  (trg_pulse),
	.rd_valid   (rd_valid)
);

`default_nettype wire

// File: tb_cal_subsys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cal_subsys;

	localparam int TMR_SEL       = 1;
	localparam int CLK_PERIOD    = 8;
	localparam int N_ROUTE       = 100;	// Random steps per routing or trigger test
	localparam int N_PULSES      = 400;
	localparam int MAX_PULSE_CYC = 7;	// Up to 3 high plus 4 low
	localparam int WRAP_PULSES   = 4100;
	localparam int WRAP_CYC      = 3;
	localparam int VALID_WAIT    = 20;	// Cycles allowed for each rd_valid
	localparam int MARGIN_CYC    = 2000;
	localparam int LIMIT_CYC     = 2 * N_ROUTE + N_PULSES * MAX_PULSE_CYC
		+ (WRAP_PULSES + 10) * WRAP_CYC + MARGIN_CYC;

	logic                      CLK40;
	logic                      RST_RESYNC;
	cal_pkg::pulse_pair_t      skw_pulse;
	cal_pkg::pulse_pair_t      lv_pulse;
	cal_pkg::ttc_mode_e        ttc_src;
	logic                      rd_strobe;
	cal_pkg::cnt_sel_e         rd_sel;
	cal_pkg::pulse_pair_t      cal_pulse;
	logic                      trg_pulse;
	logic [cal_pkg::CNT_W-1:0] rd_data;
	logic                      rd_valid;

	int    ext_edges;	// Model rising edges per channel
	int    inj_edges;
	int    n_checks;
	int    n_errors;
	int    exp_q[$];	// Expected value per outstanding strobe
	string tag_q[$];

	cal_subsys_top #(
		.TMR (TMR_SEL)
	) cal_subsys_top_inst (
		.CLK40      (CLK40),
		.RST_RESYNC (RST_RESYNC),
		.skw_pulse  (skw_pulse),
		.lv_pulse   (lv_pulse),
		.ttc_src    (ttc_src),
		.rd_strobe  (rd_strobe),
		.rd_sel     (rd_sel),
		.cal_pulse  (cal_pulse),
		.trg_pulse  (trg_pulse),
		.rd_data    (rd_data),
		.rd_valid   (rd_valid)
	);

	initial begin
		CLK40 = 1'b0;
		forever #(CLK_PERIOD / 2) CLK40 = ~CLK40;
	end

	////////////////////////////////////////
	// Reference model and checking
	////////////////////////////////////////

	// Counters wrap at 2**CNT_W
	function automatic int expected_count(input int edges);
		return edges % (1 << cal_pkg::CNT_W);
	endfunction

	function automatic cal_pkg::ttc_mode_e mode_of(input int n);
		case (n)
			0: return cal_pkg::mode_ff_emu;
			1: return cal_pkg::mode_ff_eem;
			default: return cal_pkg::mode_skew_clr;
		endcase
	endfunction

	task automatic check_value(input int actual, input int expected, input string what);
		n_checks++;
		if (actual != expected) begin
			n_errors++;
			$display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	// Sampled mid-cycle where rd_data is settled
	initial begin : compare
		int    exp_v;
		string tag;
		forever begin
			@(negedge CLK40);
			if (rd_valid) begin
				if (exp_q.size() == 0) begin
					n_errors++;
					$display("Unexpected rd_valid at %0t with no read outstanding", $time);
				end else begin
					exp_v = exp_q.pop_front();
					tag   = tag_q.pop_front();
					check_value(int'(rd_data), exp_v, tag);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (LIMIT_CYC) @(posedge CLK40);
		$display("Timeout after %0d cycles, the tests did not finish", LIMIT_CYC);
		$display("Test failed");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	// All tasks return 1 ns after a rising edge
	task automatic reset_dut();
		RST_RESYNC = 1'b1;
		repeat (3) @(posedge CLK40);
		#1;
		RST_RESYNC = 1'b0;
		ext_edges = 0;
		inj_edges = 0;
	endtask

	task automatic idle_check(input int n_cyc);
		repeat (n_cyc) begin
			@(negedge CLK40);
			check_value(int'(rd_valid), 0, "rd_valid before first strobe");
			check_value(int'(rd_data), 0, "rd_data after reset");
		end
		@(posedge CLK40);
		#1;
	endtask

	task automatic strobe_once(input cal_pkg::cnt_sel_e sel);
		rd_strobe = 1'b1;
		rd_sel    = sel;
		if (sel == cal_pkg::sel_ext) begin
			exp_q.push_back(expected_count(ext_edges));
			tag_q.push_back("ext count");
		end else begin
			exp_q.push_back(expected_count(inj_edges));
			tag_q.push_back("inj count");
		end
		@(posedge CLK40);
		#1;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < VALID_WAIT) begin
			@(posedge CLK40);
			waited++;
		end
		#1;
		if (exp_q.size() != 0) begin
			n_errors++;
			$display("No rd_valid for %0d reads after %0d cycles", exp_q.size(), VALID_WAIT);
			exp_q.delete();
			tag_q.delete();
		end
	endtask

	task automatic read_channel(input cal_pkg::cnt_sel_e sel);
		repeat (3) @(posedge CLK40);	// Pulses in flight reach the counters
		#1;
		strobe_once(sel);
		rd_strobe = 1'b0;
		wait_drain();
	endtask

	task automatic send_pulse(input cal_pkg::pulse_pair_t bits, input cal_pkg::ttc_mode_e mode,
		input int high_cyc, input int low_cyc);
		ttc_src   = mode;	// Only changes while both lines are low
		skw_pulse = bits;
		if (mode == cal_pkg::mode_skew_clr) begin
			if (bits.ext) ext_edges++;
			if (bits.inj) inj_edges++;
		end
		repeat (high_cyc) @(posedge CLK40);
		#1;
		skw_pulse = '0;
		repeat (low_cyc) @(posedge CLK40);
		#1;
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////

	task automatic route_test();
		cal_pkg::pulse_pair_t exp_pulse;
		for (int i = 0; i < N_ROUTE; i++) begin
			skw_pulse = cal_pkg::pulse_pair_t'(2'($urandom));
			ttc_src   = mode_of($urandom % 3);
			@(negedge CLK40);
			exp_pulse = (ttc_src == cal_pkg::mode_skew_clr) ? skw_pulse : '0;
			check_value(int'(cal_pulse), int'(exp_pulse), "cal_pulse");
			@(posedge CLK40);
			#1;
		end
		skw_pulse = '0;
	endtask

	task automatic trigger_test();
		for (int i = 0; i < N_ROUTE; i++) begin
			lv_pulse = cal_pkg::pulse_pair_t'(2'($urandom));
			ttc_src  = mode_of(i % 3);	// Every mode in turn
			@(negedge CLK40);
			check_value(int'(trg_pulse), int'(lv_pulse.ext | lv_pulse.inj), "trg_pulse");
			@(posedge CLK40);
			#1;
		end
		lv_pulse = '0;
	endtask

	task automatic count_test();
		cal_pkg::pulse_pair_t bits;
		int                   pick;
		for (int i = 0; i < N_PULSES; i++) begin
			bits = cal_pkg::pulse_pair_t'(2'(1 + $urandom % 3));
			pick = $urandom % 4;	// Half the pulses go out in retired modes
			send_pulse(bits, mode_of(pick), 1 + $urandom % 3, 2 + $urandom % 3);
			if (i % 100 == 99) begin
				read_channel(cal_pkg::sel_ext);
				read_channel(cal_pkg::sel_inj);
			end
		end
	endtask

	task automatic snapshot_test();
		read_channel(cal_pkg::sel_ext);
		repeat (3) @(posedge CLK40);
		#1;
		for (int i = 0; i < 6; i++) begin
			strobe_once((i % 2 == 0) ? cal_pkg::sel_inj : cal_pkg::sel_ext);
		end
		rd_strobe = 1'b0;
		wait_drain();
	endtask

	task automatic wrap_test();
		reset_dut();
		for (int i = 0; i < 5; i++) begin
			send_pulse(2'b01, cal_pkg::mode_skew_clr, 1, 2);
		end
		read_channel(cal_pkg::sel_inj);
		for (int i = 0; i < WRAP_PULSES; i++) begin
			send_pulse(2'b10, cal_pkg::mode_skew_clr, 1, 2);
		end
		read_channel(cal_pkg::sel_ext);
		read_channel(cal_pkg::sel_inj);
	endtask

	task automatic report_test(input string name, input int start_errors);
		$display("test %-16s : %0d errors", name, n_errors - start_errors);
	endtask

	initial begin : main
		int start_err;
		void'($urandom(32'hddb9));
		skw_pulse  = '0;
		lv_pulse   = '0;
		ttc_src    = cal_pkg::mode_skew_clr;
		rd_strobe  = 1'b0;
		rd_sel     = cal_pkg::sel_ext;
		RST_RESYNC = 1'b1;
		n_checks   = 0;
		n_errors   = 0;
		reset_dut();

		start_err = n_errors;
		idle_check(4);
		read_channel(cal_pkg::sel_ext);
		read_channel(cal_pkg::sel_inj);
		report_test("reset state", start_err);

		start_err = n_errors;
		route_test();
		report_test("routing", start_err);

		start_err = n_errors;
		trigger_test();
		report_test("trigger", start_err);

		// Random routing leaves stray edges in the counters
		reset_dut();
		start_err = n_errors;
		count_test();
		report_test("counting", start_err);

		start_err = n_errors;
		snapshot_test();
		report_test("snapshot", start_err);

		start_err = n_errors;
		wrap_test();
		report_test("wrap", start_err);

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
cal_pkg.sv
cal_pulse_route.sv
cal_pulse_counter.sv
cal_count_readout.sv
cal_subsys_top.sv
cal_subsys_asserts.sv
tb_cal_subsys.sv

// File: Makefile
# Verilator simulation of the calibration pulse subsystem

TOP = tb_cal_subsys
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
